// File: rtl/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // ====================
    // Geometry
    // ====================
    localparam int XLEN           = 32;                     // Processor word
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_BITS      = XLEN * WORDS_PER_LINE;  // 128-bit line
    localparam int N_WAYS         = 2;                      // One LRU bit per set

    // ====================
    // Vector types
    // ====================
    typedef logic [XLEN-1:0]                   word_t;     // Data and addresses
    typedef logic [LINE_BITS-1:0]              line_t;     // Word 0 in low bits
    typedef logic [XLEN/8-1:0]                 byte_en_t;  // One bit per byte lane
    typedef logic [$clog2(WORDS_PER_LINE)-1:0] offset_t;   // Word within line

    // Controller states
    typedef enum logic [2:0] {
        IDLE,         // Wait for processor strobe
        LOOKUP,       // Tags valid, hit or miss decided
        WRITE_BACK,   // Dirty victim out to memory
        REFILL,       // Line fetch in flight
        REFILL_DONE   // Install line, answer processor
    } cache_state_t;

    // ====================
    // Requests
    // ====================
    typedef struct packed {
        logic     rw;       // 1 = write
        byte_en_t byte_en;
        word_t    addr;
        word_t    wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  rw;          // 1 = write-back
        word_t addr;        // Line aligned
        line_t line;        // Write-back payload
    } mem_req_t;

endpackage

`default_nettype wire

// File: rtl/line_store.sv
`timescale 1ns/1ps
`default_nettype none

module line_store #(
    parameter  int N_LINES    = 8,
    localparam int INDEX_BITS = $clog2(N_LINES),
    localparam int TAG_BITS   = dcache_pkg::XLEN - INDEX_BITS
                                - $clog2(dcache_pkg::LINE_BITS / 8)
) (
    input  logic                                        clk_i,
    input  logic [INDEX_BITS-1:0]                       index_i,
    input  logic [dcache_pkg::N_WAYS-1:0]               we_i,     // One per way
    input  logic [TAG_BITS-1:0]                         tag_i,
    input  dcache_pkg::line_t                           line_i,
    output logic [dcache_pkg::N_WAYS-1:0][TAG_BITS-1:0] tag_o,
    output dcache_pkg::line_t [dcache_pkg::N_WAYS-1:0]  line_o
);

    // ====================
    // Per-way arrays
    // ====================
    for (genvar w = 0; w < dcache_pkg::N_WAYS; w++)
    begin : g_way
        logic [TAG_BITS-1:0] tag_mem [N_LINES];
        dcache_pkg::line_t   line_mem [N_LINES];
        logic [TAG_BITS-1:0] tag_q;              // Read port registers
        dcache_pkg::line_t   line_q;

        always_ff @(posedge clk_i)
        begin
            if (we_i[w])
            begin
                tag_mem[index_i]  <= tag_i;
                line_mem[index_i] <= line_i;
            end
            tag_q  <= tag_mem[index_i];          // Old contents on a same-cycle write
            line_q <= line_mem[index_i];
        end

        assign tag_o[w]  = tag_q;
        assign line_o[w] = line_q;
    end

endmodule

`default_nettype wire

// File: rtl/word_merge.sv
`timescale 1ns/1ps
`default_nettype none

module word_merge (
    input  dcache_pkg::line_t    src_line_i,    // Hit line or fill line
    input  dcache_pkg::offset_t  offset_i,
    input  dcache_pkg::byte_en_t byte_en_i,
    input  dcache_pkg::word_t    wdata_i,
    output dcache_pkg::word_t    read_word_o,
    output dcache_pkg::line_t    merged_line_o
);

    localparam int N_BYTES = dcache_pkg::XLEN / 8;

    dcache_pkg::word_t old_word;
    dcache_pkg::word_t new_word;

    // ====================
    // Word select
    // ====================
    assign old_word    = src_line_i[offset_i*dcache_pkg::XLEN +: dcache_pkg::XLEN];
    assign read_word_o = old_word;

    // Enabled lanes from write data
    always_comb
    begin
        new_word = old_word;
        for (int b = 0; b < N_BYTES; b++)
        begin
            if (byte_en_i[b])
                new_word[b*8 +: 8] = wdata_i[b*8 +: 8];
        end
    end

    // ====================
    // Line rebuild
    // ====================
    always_comb
    begin
        for (int w = 0; w < dcache_pkg::WORDS_PER_LINE; w++)
        begin
            if (w == int'(offset_i))
                merged_line_o[w*dcache_pkg::XLEN +: dcache_pkg::XLEN] = new_word;
            else                                 // Other words untouched
                merged_line_o[w*dcache_pkg::XLEN +: dcache_pkg::XLEN] =
                    src_line_i[w*dcache_pkg::XLEN +: dcache_pkg::XLEN];
        end
    end

endmodule

`default_nettype wire

// File: rtl/mem_port.sv
`timescale 1ns/1ps
`default_nettype none

module mem_port (
    input  logic                 clk_i,
    input  logic                 rst_i,
    // Controller side
    input  logic                 issue_i,       // One-cycle request pulse
    input  dcache_pkg::mem_req_t req_i,
    output logic                 done_o,
    output dcache_pkg::line_t    fill_line_o,
    // Memory bus
    output logic                 m_strobe_o,
    output logic                 m_rw_o,
    output dcache_pkg::word_t    m_addr_o,
    output dcache_pkg::line_t    m_data_o,
    input  logic                 m_ready_i,
    input  dcache_pkg::line_t    m_data_i
);

    logic accept;                                // Memory answered the live strobe

    assign accept = m_strobe_o && m_ready_i;

    // ====================
    // Strobe and direction
    // ====================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            m_strobe_o <= 1'b0;
            m_rw_o     <= 1'b0;
            done_o     <= 1'b0;
        end
        else
        begin
            done_o <= accept;                    // One cycle after ready
            if (issue_i)
            begin
                m_strobe_o <= 1'b1;
                m_rw_o     <= req_i.rw;
            end
            else if (accept)
            begin
                m_strobe_o <= 1'b0;              // Drops after the ready cycle
                m_rw_o     <= 1'b0;
            end
        end
    end

    // Address, write line and fill capture
    always_ff @(posedge clk_i)
    begin
        if (issue_i)
        begin
            m_addr_o <= req_i.addr;
            m_data_o <= req_i.line;
        end
        if (accept)
            fill_line_o <= m_data_i;             // Held until next transfer
    end

endmodule

`default_nettype wire

// File: rtl/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl #(
    parameter  int N_LINES    = 8,
    localparam int OFS_BITS   = $clog2(dcache_pkg::LINE_BITS / 8),  // Byte in line
    localparam int INDEX_BITS = $clog2(N_LINES),
    localparam int TAG_BITS   = dcache_pkg::XLEN - INDEX_BITS - OFS_BITS
) (
    input  logic                                        clk_i,
    input  logic                                        rst_i,
    // Processor side
    input  logic                                        p_strobe_i,
    input  dcache_pkg::cpu_req_t                        p_req_i,
    output logic                                        p_ready_o,
    output dcache_pkg::word_t                           p_rdata_o,
    // Store read side
    input  logic [dcache_pkg::N_WAYS-1:0][TAG_BITS-1:0] way_tag_i,
    input  dcache_pkg::line_t [dcache_pkg::N_WAYS-1:0]  way_line_i,
    // Merge logic
    input  dcache_pkg::line_t                           merged_line_i,
    input  dcache_pkg::word_t                           read_word_i,
    output dcache_pkg::cpu_req_t                        req_o,
    output dcache_pkg::line_t                           src_line_o,
    // Store write side
    output logic [INDEX_BITS-1:0]                       store_index_o,
    output logic [dcache_pkg::N_WAYS-1:0]               store_we_o,
    output logic [TAG_BITS-1:0]                         store_tag_o,
    output dcache_pkg::line_t                           store_line_o,
    // Memory port
    input  logic                                        mem_done_i,
    input  dcache_pkg::line_t                           fill_line_i,
    output logic                                        mem_issue_o,
    output dcache_pkg::mem_req_t                        mem_req_o
);

    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [TAG_BITS-1:0]   tag_t;

    dcache_pkg::cache_state_t                    state_q, state_d;
    dcache_pkg::cpu_req_t                        req_q;
    logic [N_LINES-1:0][dcache_pkg::N_WAYS-1:0]  valid_q;
    logic [N_LINES-1:0][dcache_pkg::N_WAYS-1:0]  dirty_q;
    logic [N_LINES-1:0]                          lru_q;    // Next victim way per set

    index_t                         req_index;
    tag_t                           req_tag;
    logic [dcache_pkg::N_WAYS-1:0]  way_hit;
    logic                           hit;
    logic                           hit_way;
    logic                           victim;
    logic                           victim_dirty;
    logic                           in_lookup;
    logic                           hit_write;
    logic                           fill_write;

    assign req_index = req_q.addr[OFS_BITS +: INDEX_BITS];
    assign req_tag   = req_q.addr[dcache_pkg::XLEN-1 -: TAG_BITS];
    assign req_o     = req_q;

    // Latch request while idle
    always_ff @(posedge clk_i)
    begin
        if (state_q == dcache_pkg::IDLE && p_strobe_i)
            req_q <= p_req_i;
    end

    // ====================
    // Hit detection
    // ====================
    always_comb
    begin
        for (int w = 0; w < dcache_pkg::N_WAYS; w++)
            way_hit[w] = valid_q[req_index][w] && (way_tag_i[w] == req_tag);
    end

    assign hit          = |way_hit;
    assign hit_way      = way_hit[1];            // Way 0 unless way 1 matched
    assign victim       = lru_q[req_index];
    assign victim_dirty = valid_q[req_index][victim] && dirty_q[req_index][victim];

    assign in_lookup  = (state_q == dcache_pkg::LOOKUP);
    assign hit_write  = in_lookup && hit && req_q.rw;
    assign fill_write = (state_q == dcache_pkg::REFILL_DONE);

    // ====================
    // State machine
    // ====================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            state_q <= dcache_pkg::IDLE;
        else
            state_q <= state_d;
    end

    always_comb
    begin
        state_d = state_q;                       // Hold by default
        case (state_q)
            dcache_pkg::IDLE:
                if (p_strobe_i)
                    state_d = dcache_pkg::LOOKUP;
            dcache_pkg::LOOKUP:
                if (hit)
                    state_d = dcache_pkg::IDLE;  // Answered this cycle
                else if (victim_dirty)
                    state_d = dcache_pkg::WRITE_BACK;
                else
                    state_d = dcache_pkg::REFILL;
            dcache_pkg::WRITE_BACK:
                if (mem_done_i)
                    state_d = dcache_pkg::REFILL;
            dcache_pkg::REFILL:
                if (mem_done_i)
                    state_d = dcache_pkg::REFILL_DONE;
            dcache_pkg::REFILL_DONE:
                state_d = dcache_pkg::IDLE;
            default:
                state_d = dcache_pkg::IDLE;
        endcase
    end

    // ====================
    // Valid, dirty and LRU
    // ====================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end
        else
        begin
            if (in_lookup && hit)
            begin
                lru_q[req_index] <= ~hit_way;    // Other way goes next
                if (req_q.rw)
                    dirty_q[req_index][hit_way] <= 1'b1;
            end
            if (fill_write)
            begin
                valid_q[req_index][victim] <= 1'b1;
                dirty_q[req_index][victim] <= req_q.rw;   // Write miss lands dirty
                lru_q[req_index]           <= ~victim;
            end
        end
    end

    // Store access
    // Next request's index straight from the bus so tags are ready in LOOKUP
    assign store_index_o = (state_q == dcache_pkg::IDLE && p_strobe_i) ?
                           p_req_i.addr[OFS_BITS +: INDEX_BITS] : req_index;

    always_comb
    begin
        store_we_o = '0;
        if (hit_write)
            store_we_o = way_hit;
        else if (fill_write)
            store_we_o[victim] = 1'b1;
    end

    assign store_tag_o  = req_tag;
    assign store_line_o = req_q.rw ? merged_line_i : fill_line_i;   // Fill line on read miss
    assign src_line_o   = fill_write ? fill_line_i : way_line_i[hit_way];

    // Processor response
    assign p_ready_o = (in_lookup && hit) || fill_write;
    assign p_rdata_o = (p_ready_o && !req_q.rw) ? read_word_i : '0;

    // ====================
    // Memory requests
    // ====================
    assign mem_issue_o = (in_lookup && !hit) ||
                         (state_q == dcache_pkg::WRITE_BACK && mem_done_i);  // Refill after WB

    always_comb
    begin
        mem_req_o = '0;
        if (in_lookup && victim_dirty)
        begin
            mem_req_o.rw   = 1'b1;               // Victim line address from its stored tag
            mem_req_o.addr = {way_tag_i[victim], req_index, {OFS_BITS{1'b0}}};
            mem_req_o.line = way_line_i[victim];
        end
        else
        begin
            mem_req_o.rw   = 1'b0;
            mem_req_o.addr = {req_q.addr[dcache_pkg::XLEN-1:OFS_BITS], {OFS_BITS{1'b0}}};
        end
    end

endmodule

`default_nettype wire

// File: rtl/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
    parameter int N_LINES = 8                          // Sets per way
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    // Processor side
    input  logic                 p_strobe_i,
    input  dcache_pkg::cpu_req_t p_req_i,
    output logic                 p_ready_o,
    output dcache_pkg::word_t    p_rdata_o,
    // Memory side
    output logic                 m_strobe_o,
    output logic                 m_rw_o,
    output dcache_pkg::word_t    m_addr_o,
    output dcache_pkg::line_t    m_data_o,
    input  logic                 m_ready_i,
    input  dcache_pkg::line_t    m_data_i
);

    localparam int BYTE_BITS  = $clog2(dcache_pkg::XLEN / 8);
    localparam int OFS_BITS   = $clog2(dcache_pkg::LINE_BITS / 8);
    localparam int INDEX_BITS = $clog2(N_LINES);
    localparam int TAG_BITS   = dcache_pkg::XLEN - INDEX_BITS - OFS_BITS;

    // ====================
    // Internal wires
    // ====================
    dcache_pkg::cpu_req_t                              req;        // Registered request
    dcache_pkg::line_t                                 src_line;   // Hit line or fill line
    dcache_pkg::line_t                                 merged_line;
    dcache_pkg::word_t                                 read_word;
    logic [INDEX_BITS-1:0]                             store_index;
    logic [dcache_pkg::N_WAYS-1:0]                     store_we;
    logic [TAG_BITS-1:0]                               store_tag;
    dcache_pkg::line_t                                 store_line;
    logic [dcache_pkg::N_WAYS-1:0][TAG_BITS-1:0]       way_tag;
    dcache_pkg::line_t [dcache_pkg::N_WAYS-1:0]        way_line;
    logic                                              mem_issue;
    dcache_pkg::mem_req_t                              mem_req;
    logic                                              mem_done;
    dcache_pkg::line_t                                 fill_line;

    dcache_ctrl #(
        .N_LINES (N_LINES)
    ) u_ctrl (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .p_strobe_i    (p_strobe_i),
        .p_req_i       (p_req_i),
        .way_tag_i     (way_tag),
        .way_line_i    (way_line),
        .merged_line_i (merged_line),
        .read_word_i   (read_word),
        .mem_done_i    (mem_done),
        .fill_line_i   (fill_line),
        .p_ready_o     (p_ready_o),
        .p_rdata_o     (p_rdata_o),
        .req_o         (req),
        .src_line_o    (src_line),
        .store_index_o (store_index),
        .store_we_o    (store_we),
        .store_tag_o   (store_tag),
        .store_line_o  (store_line),
        .mem_issue_o   (mem_issue),
        .mem_req_o     (mem_req)
    );

    line_store #(
        .N_LINES (N_LINES)
    ) u_store (
        .clk_i   (clk_i),
        .index_i (store_index),
        .we_i    (store_we),
        .tag_i   (store_tag),
        .line_i  (store_line),
        .tag_o   (way_tag),
        .line_o  (way_line)
    );

    word_merge u_merge (
        .src_line_i    (src_line),
        .offset_i      (req.addr[BYTE_BITS +: $bits(dcache_pkg::offset_t)]),  // Word select
        .byte_en_i     (req.byte_en),
        .wdata_i       (req.wdata),
        .read_word_o   (read_word),
        .merged_line_o (merged_line)
    );

    mem_port u_mem (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .issue_i     (mem_issue),
        .req_i       (mem_req),
        .m_ready_i   (m_ready_i),
        .m_data_i    (m_data_i),
        .m_strobe_o  (m_strobe_o),
        .m_rw_o      (m_rw_o),
        .m_addr_o    (m_addr_o),
        .m_data_o    (m_data_o),
        .done_o      (mem_done),
        .fill_line_o (fill_line)
    );

endmodule

`default_nettype wire

// File: verification/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;

    localparam int N_LINES = 8;
    localparam int TIMEOUT = 200;                        // Cycles per operation

    logic                 clk_i;
    logic                 rst_i;
    logic                 p_strobe_i;
    dcache_pkg::cpu_req_t p_req_i;
    logic                 p_ready_o;
    dcache_pkg::word_t    p_rdata_o;
    logic                 m_strobe_o;
    logic                 m_rw_o;
    dcache_pkg::word_t    m_addr_o;
    dcache_pkg::line_t    m_data_o;
    logic                 m_ready_i;
    dcache_pkg::line_t    m_data_i;

    // Memory model state
    dcache_pkg::word_t mem_words [dcache_pkg::word_t];   // Only words written back
    int                rd_count;
    int                wr_count;
    logic              wr_first;                         // Write-back seen before refill
    dcache_pkg::word_t last_rd_addr;
    dcache_pkg::word_t last_wr_addr;
    dcache_pkg::line_t last_wr_line;

    // Reference cache
    logic              ref_valid [N_LINES][2];
    logic              ref_dirty [N_LINES][2];
    logic              ref_lru   [N_LINES];              // Next victim way
    dcache_pkg::word_t ref_base  [N_LINES][2];           // Line address held by each way
    dcache_pkg::line_t ref_line  [N_LINES][2];
    int                error_count;

    dcache_top #(
        .N_LINES (N_LINES)
    ) DUT (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .p_strobe_i (p_strobe_i),
        .p_req_i    (p_req_i),
        .p_ready_o  (p_ready_o),
        .p_rdata_o  (p_rdata_o),
        .m_strobe_o (m_strobe_o),
        .m_rw_o     (m_rw_o),
        .m_addr_o   (m_addr_o),
        .m_data_o   (m_data_o),
        .m_ready_i  (m_ready_i),
        .m_data_i   (m_data_i)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;                      // 40 ns period
    end

    // ====================
    // Helpers
    // ====================
    function automatic dcache_pkg::word_t mem_word(dcache_pkg::word_t addr);
        if (mem_words.exists(addr))
            return mem_words[addr];
        return addr ^ 32'hA5A5_0000;                     // Untouched memory
    endfunction

    function automatic dcache_pkg::line_t mem_line(dcache_pkg::word_t base);
        dcache_pkg::line_t l;
        for (int i = 0; i < 4; i++)
            l[i*32 +: 32] = mem_word(base + 4*i);        // Word 0 lowest
        return l;
    endfunction

    function automatic dcache_pkg::word_t apply_bytes(dcache_pkg::word_t old,
                                                      logic [3:0] be, dcache_pkg::word_t wd);
        dcache_pkg::word_t w;
        w = old;
        for (int b = 0; b < 4; b++)
            if (be[b])
                w[b*8 +: 8] = wd[b*8 +: 8];
        return w;
    endfunction

    task automatic expect_equal(input string name, input logic [127:0] got,
                                input logic [127:0] exp);
        assert (got === exp)
        else
        begin
            $display("** Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        assert (cond)
        else
        begin
            $display("Check failed at %0t ns: %s", $time, what);
            error_count++;
        end
    endtask

    // Reference cache update and expected DUT response
    task automatic predict(input dcache_pkg::cpu_req_t req, output dcache_pkg::word_t rdata,
                           output logic hit, output logic wb, output dcache_pkg::word_t wb_addr,
                           output dcache_pkg::line_t wb_line);
        int                idx;
        int                off;
        int                way;
        dcache_pkg::word_t base;
        dcache_pkg::line_t cur;
        idx     = (req.addr >> 4) % N_LINES;
        off     = req.addr[3:2];
        base    = {req.addr[31:4], 4'h0};
        way     = -1;
        wb      = 1'b0;
        wb_addr = '0;
        wb_line = '0;
        for (int w = 0; w < 2; w++)
            if (ref_valid[idx][w] && ref_base[idx][w] == base)
                way = w;
        hit = (way >= 0);
        if (hit)
            cur = ref_line[idx][way];
        else
        begin
            way     = ref_lru[idx];                      // LRU bit names the victim
            wb      = ref_valid[idx][way] && ref_dirty[idx][way];
            wb_addr = ref_base[idx][way];
            wb_line = ref_line[idx][way];
            cur     = mem_line(base);
            ref_valid[idx][way] = 1'b1;
            ref_dirty[idx][way] = 1'b0;
            ref_base[idx][way]  = base;
        end
        rdata = req.rw ? '0 : cur[off*32 +: 32];
        if (req.rw)
        begin
            cur[off*32 +: 32]   = apply_bytes(cur[off*32 +: 32], req.byte_en, req.wdata);
            ref_dirty[idx][way] = 1'b1;
        end
        ref_line[idx][way] = cur;
        ref_lru[idx]       = (way == 0);                 // Other way goes next
    endtask

    task automatic issue_op(input dcache_pkg::cpu_req_t req, output int cycles,
                            output dcache_pkg::word_t rdata, output logic timed_out);
        @(posedge clk_i);
        p_strobe_i <= 1'b1;
        p_req_i    <= req;
        @(posedge clk_i);
        p_strobe_i <= 1'b0;
        cycles = 0;
        do
        begin
            @(negedge clk_i);                            // Outputs settled
            cycles++;
        end
        while (!p_ready_o && cycles < TIMEOUT);
        rdata     = p_rdata_o;
        timed_out = !p_ready_o;
    endtask

    // ====================
    // Memory model
    // ====================
    initial
    begin : memory_model
        int delay;
        void'($urandom(32'h5f36_4b76));
        m_ready_i = 1'b0;
        m_data_i  = '0;
        forever
        begin
            @(negedge clk_i);
            if (m_strobe_o)
            begin
                delay = 1 + ($urandom % 4);              // 1 to 4 cycles
                if (m_rw_o)
                begin
                    wr_count++;
                    last_wr_addr = m_addr_o;
                    last_wr_line = m_data_o;
                    for (int i = 0; i < 4; i++)
                        mem_words[m_addr_o + 4*i] = m_data_o[i*32 +: 32];
                end
                else
                begin
                    rd_count++;
                    last_rd_addr = m_addr_o;
                    wr_first     = (wr_count > 0);
                end
                repeat (delay) @(posedge clk_i);
                m_ready_i <= 1'b1;
                m_data_i  <= m_rw_o ? '0 : mem_line(m_addr_o);
                @(posedge clk_i);
                m_ready_i <= 1'b0;                       // One-cycle pulse
            end
        end
    end

    // ====================
    // Stimulus
    // ====================
    initial
    begin : stimulus
        int                   fd;
        int                   fields;
        int                   op;
        int                   be;
        int                   wb_file;
        int                   test_no;
        int                   failed_tests;
        int                   err_before;
        int                   cycles;
        dcache_pkg::word_t    addr;
        dcache_pkg::word_t    wdata;
        dcache_pkg::word_t    rdata_file;
        dcache_pkg::word_t    exp_rdata;
        dcache_pkg::word_t    got_rdata;
        dcache_pkg::word_t    wb_addr;
        dcache_pkg::line_t    wb_line;
        dcache_pkg::cpu_req_t req;
        logic                 hit;
        logic                 exp_wb;
        logic                 timed_out;
        string                text;

        rst_i        = 1'b1;
        p_strobe_i   = 1'b0;
        p_req_i      = '0;
        error_count  = 0;
        test_no      = 0;
        failed_tests = 0;
        timed_out    = 1'b0;
        for (int s = 0; s < N_LINES; s++)
        begin
            ref_lru[s] = 1'b0;
            for (int w = 0; w < 2; w++)
            begin
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
                ref_base[s][w]  = '0;
                ref_line[s][w]  = '0;
            end
        end

        repeat (10) @(posedge clk_i);
        rst_i <= 1'b0;
        repeat (3)                                       // Quiet until first strobe
        begin
            @(negedge clk_i);
            expect_true(!p_ready_o && !m_strobe_o && !m_rw_o, "outputs not low after reset");
        end

        fd = $fopen("verification/dcache_tests.txt", "r");
        expect_true(fd != 0, "cannot open verification/dcache_tests.txt");
        while (fd != 0 && !timed_out && $fgets(text, fd) > 0)
        begin
            fields = $sscanf(text, "%c %h %h %h %h %d", op, addr, be, wdata, rdata_file,
                             wb_file);
            if (fields == 6 && (op == "R" || op == "W"))     // Comment lines skipped
            begin
                test_no++;
                err_before    = error_count;
                req.rw        = (op == "W");
                req.byte_en   = be[3:0];
                req.addr      = addr;
                req.wdata     = wdata;
                predict(req, exp_rdata, hit, exp_wb, wb_addr, wb_line);
                expect_equal("read data in file", rdata_file, exp_rdata);
                expect_equal("write-back flag in file", wb_file, exp_wb);
                rd_count = 0;
                wr_count = 0;
                wr_first = 1'b0;
                issue_op(req, cycles, got_rdata, timed_out);
                if (timed_out)
                    $display("Timeout: no p_ready_o within %0d cycles on test %0d",
                             TIMEOUT, test_no);
                else
                begin
                    expect_equal("p_rdata_o", got_rdata, exp_rdata);
                    expect_equal("memory write count", wr_count, exp_wb);
                    if (hit)
                    begin
                        expect_equal("hit latency", cycles, 1);
                        expect_equal("memory read count", rd_count, 0);
                    end
                    else
                    begin
                        expect_equal("memory read count", rd_count, 1);
                        expect_equal("m_addr_o refill", last_rd_addr, {addr[31:4], 4'h0});
                    end
                    if (exp_wb)
                    begin
                        expect_equal("m_addr_o write-back", last_wr_addr, wb_addr);
                        expect_equal("m_data_o write-back", last_wr_line, wb_line);
                        expect_true(wr_first, "refill read issued before the write-back");
                    end
                end
                if (error_count != err_before || timed_out)
                    failed_tests++;
                $display("test %0d: %s %h be %h -> %s", test_no, req.rw ? "W" : "R", addr,
                         be[3:0], (error_count == err_before && !timed_out) ? "ok" : "bad");
            end
        end
        if (fd != 0)
            $fclose(fd);

        $display("%0d tests, %0d failed, %0d check errors", test_no, failed_tests,
                 error_count);
        if (error_count == 0 && !timed_out && test_no > 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
rtl/dcache_pkg.sv
rtl/line_store.sv
rtl/word_merge.sv
rtl/mem_port.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
verification/tb_dcache.sv

// File: verification/dcache_tests.txt
# op addr be wdata rdata wb : R read, W write, hex fields, be is byte enable
# rdata is the expected read word (0 on writes), wb is 1 when a write-back is expected
R 00000014 0 00000000 a5a50014 0
R 00000018 0 00000000 a5a50018 0
W 0000001c f 12345678 00000000 0
R 0000001c 0 00000000 12345678 0
W 00000010 3 deadbeef 00000000 0
R 00000010 0 00000000 a5a5beef 0
W 00000098 c cafef00d 00000000 0
R 00000098 0 00000000 cafe0098 0
R 00000114 0 00000000 a5a50114 1
R 00000010 0 00000000 a5a5beef 1
R 0000001c 0 00000000 12345678 0
R 00000098 0 00000000 cafe0098 0
W 00000114 1 000000ab 00000000 0
R 00000114 0 00000000 a5a501ab 0
R 00000190 0 00000000 a5a50190 0
R 00000010 0 00000000 a5a5beef 1
R 00001024 0 00000000 a5a51024 0
R 000010a8 0 00000000 a5a510a8 0
R 00001020 0 00000000 a5a51020 0
R 0000112c 0 00000000 a5a5112c 0
R 000010a0 0 00000000 a5a510a0 0
W 00000234 f 0badc0de 00000000 0
R 00000234 0 00000000 0badc0de 0
R 00000230 0 00000000 a5a50230 0
W ffffff48 6 11223344 00000000 0
R ffffff48 0 00000000 5a223348 0
R ffffff44 0 00000000 5a5aff44 0
